// ==== Makefile ====
VERILATOR ?= verilator
TOP       := cnn_fetch_tb
FILELIST  := cnn_fetch.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing -Wno-fatal -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== cnn_fetch.f ====
+incdir+hw
hw/cnn_fetch_pkg.sv
hw/inst_decode.sv
hw/ddr_fetch_engine.sv
hw/ddr_read_arbiter.sv
hw/cnn_fetch_top.sv
verification/cnn_fetch_tb.sv

// ==== hw/cnn_fetch_defs.svh ====
`ifndef CNN_FETCH_DEFS_SVH
`define CNN_FETCH_DEFS_SVH

////////////////////////////////////////////////////////////
// ddr side
////////////////////////////////////////////////////////////

`define DDR_DATA_LEN 512   // one read beat
`define DDR_ADDR_LEN 32    // byte address
`define BEAT_BYTES   64    // address step per beat

// beats per request
`define BEAT_CNT_LEN 12

////////////////////////////////////////////////////////////
// on-chip buffers
////////////////////////////////////////////////////////////

`define ADDR_LEN_WB 13     // weight buffer
`define ADDR_LEN_BB 7      // bias buffer

`endif

// ==== hw/cnn_fetch_pkg.sv ====
`default_nettype none

`include "cnn_fetch_defs.svh"

package cnn_fetch_pkg;

	// load kinds carried in an instruction
	typedef enum logic [1:0] {
		op_nop,
		op_load_weight,
		op_load_bias,
		op_load_both
	} opcode_e;

	typedef enum logic [1:0] {
		st_idle,
		st_request,   // command out, waiting for the port
		st_stream     // popping beats
	} fetch_state_e;

	// one block transfer, handed to a fetch engine
	typedef struct packed {
		logic [`DDR_ADDR_LEN-1:0] ddr_addr;
		logic [`BEAT_CNT_LEN-1:0] beat_cnt;
		logic [`ADDR_LEN_WB-1:0]  buf_addr;   // bias engine takes the low bits
	} fetch_job_t;

	// opcode first, then the weight job, then the bias job
	typedef struct packed {
		opcode_e    op;
		fetch_job_t wt;
		fetch_job_t bb;
	} inst_t;

	typedef struct packed {
		logic [`DDR_ADDR_LEN-1:0] ddr_addr;
		logic [`BEAT_CNT_LEN-1:0] beat_cnt;
	} ddr_cmd_t;

	typedef struct packed {
		logic [`ADDR_LEN_WB-1:0]  addr;
		logic [`DDR_DATA_LEN-1:0] data;
	} buf_wr_t;

endpackage

`default_nettype wire

// ==== hw/cnn_fetch_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cnn_fetch_defs.svh"

module cnn_fetch_top import cnn_fetch_pkg::*; (
	input  logic                     clk,
	input  logic                     rst,
	input  inst_t                    instruct,
	input  logic                     inst_empty,
	output logic                     inst_req,
	output ddr_cmd_t                 ddr_cmd,
	output logic                     ddr_conf,
	input  logic                     ddr_fifo_empty,
	output logic                     ddr_fifo_req,
	input  logic [`DDR_DATA_LEN-1:0] ddr_fifo_data,
	output logic                     wb_wea,
	output buf_wr_t                  wb_wr,
	output logic                     bb_wea,
	output buf_wr_t                  bb_wr,
	output logic                     idle
);

	fetch_job_t wt_job, bb_job;
	logic       wt_conf, bb_conf;
	logic       wt_idle, bb_idle;
	ddr_cmd_t   wt_cmd, bb_cmd;
	logic       wt_cmd_conf, bb_cmd_conf;
	logic       wt_fifo_req, bb_fifo_req;
	logic       wt_fifo_empty, bb_fifo_empty;

	inst_decode u_decode (
		.clk        (clk),
		.rst        (rst),
		.instruct   (instruct),
		.inst_empty (inst_empty),
		.inst_req   (inst_req),
		.wt_idle    (wt_idle),
		.bb_idle    (bb_idle),
		.wt_conf    (wt_conf),
		.bb_conf    (bb_conf),
		.wt_job     (wt_job),
		.bb_job     (bb_job),
		.idle       (idle)
	);

	////////////////////////////////////////////////////////////
	// fetch engines, data bus goes to both
	////////////////////////////////////////////////////////////

	ddr_fetch_engine #(.BUF_ADDR_LEN(`ADDR_LEN_WB)) u_wfc (
		.clk        (clk),
		.rst        (rst),
		.conf       (wt_conf),
		.job        (wt_job),
		.cmd        (wt_cmd),
		.cmd_conf   (wt_cmd_conf),
		.fifo_empty (wt_fifo_empty),
		.fifo_req   (wt_fifo_req),
		.fifo_data  (ddr_fifo_data),
		.wea        (wb_wea),
		.wr         (wb_wr),
		.idle       (wt_idle)
	);

	ddr_fetch_engine #(.BUF_ADDR_LEN(`ADDR_LEN_BB)) u_bfc (
		.clk        (clk),
		.rst        (rst),
		.conf       (bb_conf),
		.job        (bb_job),
		.cmd        (bb_cmd),
		.cmd_conf   (bb_cmd_conf),
		.fifo_empty (bb_fifo_empty),
		.fifo_req   (bb_fifo_req),
		.fifo_data  (ddr_fifo_data),
		.wea        (bb_wea),
		.wr         (bb_wr),
		.idle       (bb_idle)
	);

	ddr_read_arbiter u_arb (
		.clk            (clk),
		.rst            (rst),
		.wt_cmd         (wt_cmd),
		.bb_cmd         (bb_cmd),
		.wt_cmd_conf    (wt_cmd_conf),
		.bb_cmd_conf    (bb_cmd_conf),
		.wt_idle        (wt_idle),
		.bb_idle        (bb_idle),
		.wt_fifo_req    (wt_fifo_req),
		.bb_fifo_req    (bb_fifo_req),
		.wt_fifo_empty  (wt_fifo_empty),
		.bb_fifo_empty  (bb_fifo_empty),
		.ddr_cmd        (ddr_cmd),
		.ddr_conf       (ddr_conf),
		.ddr_fifo_empty (ddr_fifo_empty),
		.ddr_fifo_req   (ddr_fifo_req)
	);

endmodule

`default_nettype wire

// ==== hw/ddr_fetch_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cnn_fetch_defs.svh"

module ddr_fetch_engine import cnn_fetch_pkg::*; #(
	parameter int BUF_ADDR_LEN = `ADDR_LEN_WB
) (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     conf,
	input  fetch_job_t               job,
	output ddr_cmd_t                 cmd,
	output logic                     cmd_conf,
	input  logic                     fifo_empty,
	output logic                     fifo_req,
	input  logic [`DDR_DATA_LEN-1:0] fifo_data,
	output logic                     wea,
	output buf_wr_t                  wr,
	output logic                     idle
);

	fetch_state_e             state;
	logic [`BEAT_CNT_LEN-1:0] beats_left;
	logic [BUF_ADDR_LEN-1:0]  buf_ptr;     // wraps at the buffer depth
	logic [`ADDR_LEN_WB-1:0]  ptr_ext;
	logic                     start;

	assign start = (state == st_idle) && conf && (job.beat_cnt != '0);

	// pop whenever a beat sits at the head
	assign fifo_req = (state == st_stream) && !fifo_empty;

	// still busy while the last write is in flight
	assign idle = (state == st_idle) && !wea;

	always_comb begin
		ptr_ext = '0;
		ptr_ext[BUF_ADDR_LEN-1:0] = buf_ptr;
	end

	////////////////////////////////////////////////////////////
	// control
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			state      <= st_idle;
			cmd_conf   <= 1'b0;
			beats_left <= '0;
			buf_ptr    <= '0;
			wea        <= 1'b0;
		end else begin
			cmd_conf <= start;
			wea      <= fifo_req;   // write follows the pop by one cycle
			case (state)
				st_idle: begin
					if (start) begin
						beats_left <= job.beat_cnt;
						buf_ptr    <= job.buf_addr[BUF_ADDR_LEN-1:0];
						state      <= st_request;
					end
				end
				st_request: begin
					// data only shows up once the arbiter hands us the port
					if (!fifo_empty) state <= st_stream;
				end
				st_stream: begin
					if (fifo_req) begin
						beats_left <= beats_left - 1'b1;
						buf_ptr    <= buf_ptr + 1'b1;
						if (beats_left == 'd1) state <= st_idle;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	// payload
	always_ff @(posedge clk) begin
		if (start) begin
			cmd.ddr_addr <= job.ddr_addr;
			cmd.beat_cnt <= job.beat_cnt;
		end
		if (fifo_req) begin
			wr.addr <= ptr_ext;
			wr.data <= fifo_data;
		end
	end

endmodule

`default_nettype wire

// ==== hw/ddr_read_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module ddr_read_arbiter import cnn_fetch_pkg::*; (
	input  logic     clk,
	input  logic     rst,
	input  ddr_cmd_t wt_cmd,
	input  ddr_cmd_t bb_cmd,
	input  logic     wt_cmd_conf,
	input  logic     bb_cmd_conf,
	input  logic     wt_idle,
	input  logic     bb_idle,
	input  logic     wt_fifo_req,
	input  logic     bb_fifo_req,
	output logic     wt_fifo_empty,
	output logic     bb_fifo_empty,
	output ddr_cmd_t ddr_cmd,
	output logic     ddr_conf,
	input  logic     ddr_fifo_empty,
	output logic     ddr_fifo_req
);

	ddr_cmd_t wt_cmd_q;
	ddr_cmd_t bb_cmd_q;
	logic     wt_pend;
	logic     bb_pend;
	logic     busy;        // port owned by an engine
	logic     own_bb;      // switch, low selects weights
	logic     grant_wt;
	logic     grant_bb;
	logic     owner_idle;

	// weights win a tie
	assign grant_wt   = !busy && wt_pend;
	assign grant_bb   = !busy && !wt_pend && bb_pend;
	assign owner_idle = own_bb ? bb_idle : wt_idle;

	always_ff @(posedge clk) begin
		if (rst) begin
			wt_pend  <= 1'b0;
			bb_pend  <= 1'b0;
			busy     <= 1'b0;
			own_bb   <= 1'b0;
			ddr_conf <= 1'b0;
		end else begin
			if (wt_cmd_conf) wt_pend <= 1'b1;
			else if (grant_wt) wt_pend <= 1'b0;
			if (bb_cmd_conf) bb_pend <= 1'b1;
			else if (grant_bb) bb_pend <= 1'b0;

			ddr_conf <= grant_wt || grant_bb;

			if (grant_wt || grant_bb) begin
				busy   <= 1'b1;
				own_bb <= grant_bb;
			end else if (busy && owner_idle) begin
				busy <= 1'b0;   // owner done with its last write
			end
		end
	end

	always_ff @(posedge clk) begin
		if (wt_cmd_conf) wt_cmd_q <= wt_cmd;
		if (bb_cmd_conf) bb_cmd_q <= bb_cmd;
		if (grant_wt) ddr_cmd <= wt_cmd_q;
		else if (grant_bb) ddr_cmd <= bb_cmd_q;
	end

	////////////////////////////////////////////////////////////
	// read fifo routing
	////////////////////////////////////////////////////////////

	assign wt_fifo_empty = ddr_fifo_empty || !(busy && !own_bb);
	assign bb_fifo_empty = ddr_fifo_empty || !(busy && own_bb);
	assign ddr_fifo_req  = busy && (own_bb ? bb_fifo_req : wt_fifo_req);

endmodule

`default_nettype wire

// ==== hw/inst_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module inst_decode import cnn_fetch_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  inst_t      instruct,
	input  logic       inst_empty,
	output logic       inst_req,
	input  logic       wt_idle,
	input  logic       bb_idle,
	output logic       wt_conf,
	output logic       bb_conf,
	output fetch_job_t wt_job,
	output fetch_job_t bb_job,
	output logic       idle
);

	inst_t inst_q;        // popped instruction
	logic  starting;      // popped last cycle, conf pulses go out now
	logic  engines_idle;

	assign engines_idle = wt_idle && bb_idle;

	// show-ahead fifo, head entry is taken in the cycle of the pop
	assign inst_req = !inst_empty && engines_idle && !starting;

	always_ff @(posedge clk) begin
		if (rst) begin
			starting <= 1'b0;
		end else begin
			starting <= inst_req;
		end
	end

	always_ff @(posedge clk) begin
		if (inst_req) begin
			inst_q <= instruct;
		end
	end

	////////////////////////////////////////////////////////////
	// opcode decode
	////////////////////////////////////////////////////////////

	always_comb begin
		wt_conf = 1'b0;
		bb_conf = 1'b0;
		if (starting) begin
			case (inst_q.op)
				op_load_weight: wt_conf = 1'b1;
				op_load_bias:   bb_conf = 1'b1;
				op_load_both: begin
					wt_conf = 1'b1;
					bb_conf = 1'b1;
				end
				default: ;   // nop starts nothing
			endcase
		end
	end

	assign wt_job = inst_q.wt;
	assign bb_job = inst_q.bb;

	assign idle = inst_empty && !starting && engines_idle;

endmodule

`default_nettype wire

// ==== verification/cnn_fetch_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cnn_fetch_defs.svh"

module cnn_fetch_tb import cnn_fetch_pkg::*; ();

	logic                     clk = 1'b0;
	logic                     rst = 1'b1;
	inst_t                    instruct = '0;
	logic                     inst_empty = 1'b1;
	logic                     ddr_fifo_empty = 1'b1;
	logic [`DDR_DATA_LEN-1:0] ddr_fifo_data = '0;
	logic                     inst_req, ddr_conf, ddr_fifo_req, wb_wea, bb_wea, idle;
	ddr_cmd_t                 ddr_cmd;
	buf_wr_t                  wb_wr, bb_wr;

	// op, weight ddr addr / beats / buffer start, bias ddr addr / beats / buffer start
	inst_t tests [8] = '{
		{op_load_weight, 32'h0001_0000, 12'd5, 13'h0020, 32'h0009_0000, 12'd2, 13'h0003},
		{op_nop,         32'h0001_0000, 12'd4, 13'h0000, 32'h0009_0000, 12'd4, 13'h0000},
		{op_load_bias,   32'h0002_0000, 12'd7, 13'h0000, 32'h0002_0800, 12'd4, 13'h007d},
		{op_load_both,   32'h0003_0400, 12'd3, 13'h1ffe, 32'h0004_0000, 12'd6, 13'h0010},
		{op_load_weight, 32'h0005_0000, 12'd8, 13'h0100, 32'h000a_0000, 12'd3, 13'h0000},
		{op_nop,         32'h000b_0000, 12'd2, 13'h0040, 32'h000c_0000, 12'd2, 13'h0040},
		{op_load_both,   32'h0006_0040, 12'd2, 13'h0a00, 32'h0007_00c0, 12'd2, 13'h007f},
		{op_load_bias,   32'h0008_0000, 12'd9, 13'h0000, 32'h0008_1000, 12'd3, 13'h0040}
	};

	inst_t                    inst_fifo [$];
	logic [`DDR_DATA_LEN-1:0] ddr_q [$];      // beats requested, not yet popped
	ddr_cmd_t                 exp_cmd [$];
	buf_wr_t                  exp_wr [$];
	logic                     exp_bias [$];   // buffer of each expected write
	int                       inst_avail = 0;
	int                       ddr_avail = 0;  // beats already landed in the read fifo
	int                       total_beats = 0;
	int                       cycle_limit = 0;
	logic [31:0]              lfsr = 32'h03fb6990;

	cnn_fetch_top dut0 (.*);

	always #50 clk = ~clk;

	// fibonacci, taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// word w of beat k holds A + 64k + w
	function automatic logic [`DDR_DATA_LEN-1:0] beat_data(input logic [31:0] addr, input int k);
		logic [`DDR_DATA_LEN-1:0] d;
		int                       w;
		for (w = 0; w < `DDR_DATA_LEN / 32; w++)
			d[32*w +: 32] = addr + `BEAT_BYTES * k + w;
		return d;
	endfunction

	task automatic stop_with_failure(input string msg);
		$display("%s", msg);
		$display("RESULT: FAIL");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_value(input string name, input logic [`DDR_DATA_LEN-1:0] got,
			input logic [`DDR_DATA_LEN-1:0] exp);
		if (got !== exp)
			stop_with_failure($sformatf("mismatch at %0t: %s is %0h, expected %0h",
				$time, name, got, exp));
	endtask

	task automatic expect_load(input logic is_bias, input fetch_job_t job);
		ddr_cmd_t cmd;
		buf_wr_t  wr;
		int       k;
		cmd.ddr_addr = job.ddr_addr;
		cmd.beat_cnt = job.beat_cnt;
		exp_cmd.push_back(cmd);
		for (k = 0; k < job.beat_cnt; k++) begin
			wr.addr = job.buf_addr + 13'(k);
			if (is_bias) wr.addr[`ADDR_LEN_WB-1:`ADDR_LEN_BB] = '0;   // wraps at 128
			wr.data = beat_data(job.ddr_addr, k);
			exp_wr.push_back(wr);
			exp_bias.push_back(is_bias);
		end
		total_beats += job.beat_cnt;
	endtask

	////////////////////////////////////////////////////////////
	// DDR and instruction FIFO models
	////////////////////////////////////////////////////////////

	task automatic take_command();
		int k;
		if (exp_cmd.size() == 0) begin
			stop_with_failure("ddr_conf was issued while no DDR command was expected");
		end else begin
			check_value("ddr_cmd.ddr_addr", ddr_cmd.ddr_addr, exp_cmd[0].ddr_addr);
			check_value("ddr_cmd.beat_cnt", ddr_cmd.beat_cnt, exp_cmd[0].beat_cnt);
			exp_cmd.delete(0);
			for (k = 0; k < ddr_cmd.beat_cnt; k++)
				ddr_q.push_back(beat_data(ddr_cmd.ddr_addr, k));
		end
	endtask

	task automatic check_write(input logic is_bias, input buf_wr_t got);
		string name;
		name = is_bias ? "bb_wr" : "wb_wr";
		if (exp_wr.size() == 0 || exp_bias[0] != is_bias) begin
			stop_with_failure({name, " was written out of order or without a load"});
		end else begin
			check_value({name, ".addr"}, got.addr, exp_wr[0].addr);
			check_value({name, ".data"}, got.data, exp_wr[0].data);
			exp_wr.delete(0);
			exp_bias.delete(0);
		end
	endtask

	task automatic drive_inputs();
		lfsr = lfsr_step(lfsr);
		if (inst_avail == 0 && inst_fifo.size() != 0 && lfsr[0]) inst_avail = 1;
		inst_empty = (inst_avail == 0);
		if (inst_avail != 0) instruct = inst_fifo[0];
		// a beat lands unless both bits are zero
		lfsr = lfsr_step(lfsr);
		lfsr = lfsr_step(lfsr);
		if (ddr_avail < ddr_q.size() && lfsr[1:0] != 2'b00) ddr_avail++;
		ddr_fifo_empty = (ddr_avail == 0);
		if (ddr_avail != 0) ddr_fifo_data = ddr_q[0];
	endtask

	// outputs only move at the rising edge, inputs only at the falling one
	always @(posedge clk) begin
		if (!rst) begin
			if (ddr_fifo_req && ddr_fifo_empty) begin
				stop_with_failure("ddr_fifo_req rose while the DDR read FIFO was empty");
			end else if (ddr_fifo_req) begin
				ddr_q.delete(0);
				ddr_avail--;
			end
			if (inst_req) begin
				inst_fifo.delete(0);
				inst_avail = 0;
			end
			if (ddr_conf) take_command();
			if (wb_wea) check_write(1'b0, wb_wr);
			if (bb_wea) check_write(1'b1, bb_wr);
		end
	end

	initial begin : watchdog
		wait (cycle_limit != 0);
		repeat (cycle_limit) @(posedge clk);
		stop_with_failure("timeout, the loads did not finish in time");
	end

	////////////////////////////////////////////////////////////
	// main sequence
	////////////////////////////////////////////////////////////

	initial begin : main
		foreach (tests[i]) begin
			inst_fifo.push_back(tests[i]);
			if (tests[i].op inside {op_load_weight, op_load_both}) expect_load(1'b0, tests[i].wt);
			if (tests[i].op inside {op_load_bias, op_load_both}) expect_load(1'b1, tests[i].bb);
		end
		cycle_limit = 40 * total_beats + 200;

		repeat (16) @(posedge clk);
		@(negedge clk);
		check_value("inst_req", inst_req, 1'b0);
		check_value("ddr_conf", ddr_conf, 1'b0);
		check_value("ddr_fifo_req", ddr_fifo_req, 1'b0);
		check_value("wb_wea", wb_wea, 1'b0);
		check_value("bb_wea", bb_wea, 1'b0);
		check_value("idle", idle, 1'b1);
		rst = 1'b0;

		while (inst_fifo.size() != 0 || exp_wr.size() != 0 || !idle) begin
			drive_inputs();
			@(negedge clk);
		end

		if (exp_cmd.size() == 0 && ddr_q.size() == 0) begin
			$display("RESULT: PASS");
			$finish;
		end else begin
			stop_with_failure("the run ended with DDR commands or beats left unused");
		end
	end

endmodule

`default_nettype wire
